// File: common/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    // ==================================================
    // field widths
    // ==================================================
    localparam int opW    = 6;   // instr[31:26]
    localparam int functW = 6;   // instr[5:0]
    localparam int rtW    = 5;   // instr[20:16]
    localparam int aluOpW = 6;
    localparam int dmOpW  = 3;

    // opcode field, only the kept ones
    typedef enum logic [opW-1:0] {
        OP_RTYPE  = 6'd0,
        OP_REGIMM = 6'd1,    // bltz / bgez, picked by rt
        OP_J      = 6'd2,
        OP_JAL    = 6'd3,
        OP_BEQ    = 6'd4,
        OP_BNE    = 6'd5,
        OP_BLEZ   = 6'd6,
        OP_BGTZ   = 6'd7,
        OP_ADDI   = 6'd8,
        OP_LUI    = 6'd15,
        OP_LB     = 6'd32,
        OP_LH     = 6'd33,
        OP_LW     = 6'd35,
        OP_SB     = 6'd40,
        OP_SH     = 6'd41,
        OP_SW     = 6'd43
    } opcodeT;

    // function field under OP_RTYPE
    typedef enum logic [functW-1:0] {
        FN_JR   = 6'd8,
        FN_MFHI = 6'd16,
        FN_MTHI = 6'd17,
        FN_MFLO = 6'd18,
        FN_MTLO = 6'd19
    } functT;

    // rt values under OP_REGIMM
    localparam logic [rtW-1:0] rtBgez = 5'd1;
    localparam logic [rtW-1:0] rtBltz = 5'd0;   // any rt other than rtBgez lands here

    // alu operation, same numbering the alu decodes
    typedef enum logic [aluOpW-1:0] {
        ALU_AND  = 6'd0,
        ALU_ADD  = 6'd2,
        ALU_MTHI = 6'd10,
        ALU_MTLO = 6'd11,
        ALU_MFHI = 6'd12,
        ALU_MFLO = 6'd13,
        ALU_BEQ  = 6'd16,
        ALU_BGTZ = 6'd17,
        ALU_BGEZ = 6'd18,
        ALU_BLEZ = 6'd19,
        ALU_BLTZ = 6'd20,
        ALU_BNE  = 6'd21,
        ALU_LUI  = 6'd32    // imm << 16
    } aluOpT;

    // data memory access size and direction
    typedef enum logic [dmOpW-1:0] {
        WORD_LOAD  = 3'd0,
        WORD_STORE = 3'd1,
        BYTE_LOAD  = 3'd2,
        BYTE_STORE = 3'd3,
        HALF_LOAD  = 3'd4,
        HALF_STORE = 3'd5
    } dmOpT;

    // regfile write data mux, code 2 unused
    typedef enum logic [1:0] {
        FROM_RESULT = 2'd0,   // memtoReg mux output
        FROM_R31    = 2'd1,
        FROM_PC4    = 2'd3
    } writeDstT;

    // ==================================================
    // structs
    // ==================================================
    typedef struct packed {
        opcodeT           op;
        logic [rtW-1:0]   rt;
        functT            funct;
    } instrFieldsT;

    typedef struct packed {
        logic     regDst;      // 1: rd, 0: rt
        logic     branch;
        logic     memRead;
        logic     memtoReg;    // 1: alu result, 0: dmem data
        logic     memWrite;
        logic     aluSrc2;     // 1: immExt on alu B
        logic     regWrite;
        logic     signExt;     // 0: zero extend
        logic     jump;
        writeDstT writeDst;
        aluOpT    aluControl;
        dmOpT     dmControl;
    } ctrlWordT;

    // all zero, also the reset value of the id/ex register
    localparam ctrlWordT ctrlIdle = '{
        regDst: 1'b0, branch: 1'b0, memRead: 1'b0, memtoReg: 1'b0,
        memWrite: 1'b0, aluSrc2: 1'b0, regWrite: 1'b0, signExt: 1'b0,
        jump: 1'b0, writeDst: FROM_RESULT, aluControl: ALU_AND,
        dmControl: WORD_LOAD
    };

    // fallback word for unknown opcodes and function codes
    localparam ctrlWordT ctrlAndWord = '{
        regDst: 1'b1, branch: 1'b0, memRead: 1'b0, memtoReg: 1'b1,
        memWrite: 1'b0, aluSrc2: 1'b0, regWrite: 1'b1, signExt: 1'b0,
        jump: 1'b0, writeDst: FROM_RESULT, aluControl: ALU_AND,
        dmControl: WORD_LOAD
    };

endpackage

`default_nettype wire

// File: hw/decode/opDecoder.sv
`default_nettype none

module opDecoder (
    input  ctrlPkg::opcodeT           op,
    input  logic [ctrlPkg::rtW-1:0]   rt,
    output ctrlPkg::ctrlWordT         opCtrl,
    output logic                      isRType
);
    import ctrlPkg::*;

    dmOpT  dmSel;       // access size per load/store opcode
    aluOpT branchOp;    // compare op per branch opcode

    // ==================================================
    // per-opcode sub codes
    // ==================================================
    always_comb begin
        case (op)
            OP_LB:   dmSel = BYTE_LOAD;
            OP_LH:   dmSel = HALF_LOAD;
            OP_SW:   dmSel = WORD_STORE;
            OP_SB:   dmSel = BYTE_STORE;
            OP_SH:   dmSel = HALF_STORE;
            default: dmSel = WORD_LOAD;   // lw, lui
        endcase
    end

    always_comb begin
        case (op)
            OP_BNE:    branchOp = ALU_BNE;
            OP_BGTZ:   branchOp = ALU_BGTZ;
            OP_BLEZ:   branchOp = ALU_BLEZ;
            // regimm splits on rt, only rt==1 is bgez
            OP_REGIMM: branchOp = (rt == rtBgez) ? ALU_BGEZ : ALU_BLTZ;
            default:   branchOp = ALU_BEQ;
        endcase
    end

    // ==================================================
    // main decode
    // ==================================================
    always_comb begin
        opCtrl = ctrlIdle;    // unlisted fields stay 0
        case (op)
            OP_RTYPE: begin
                // funct decoder owns this word, keep idle
                opCtrl = ctrlIdle;
            end
            OP_LW, OP_LB, OP_LH: begin
                opCtrl.memRead    = 1'b1;
                opCtrl.aluSrc2    = 1'b1;    // base + offset
                opCtrl.regWrite   = 1'b1;
                opCtrl.signExt    = 1'b1;
                opCtrl.aluControl = ALU_ADD;
                opCtrl.dmControl  = dmSel;
            end
            OP_LUI: begin
                opCtrl.memtoReg   = 1'b1;    // result straight from alu
                opCtrl.aluSrc2    = 1'b1;
                opCtrl.regWrite   = 1'b1;
                opCtrl.signExt    = 1'b1;
                opCtrl.aluControl = ALU_LUI;
                opCtrl.dmControl  = dmSel;
            end
            OP_SW, OP_SB, OP_SH: begin
                opCtrl.memWrite   = 1'b1;
                opCtrl.aluSrc2    = 1'b1;
                opCtrl.signExt    = 1'b1;
                opCtrl.aluControl = ALU_ADD;  // address calc
                opCtrl.dmControl  = dmSel;
            end
            OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ, OP_REGIMM: begin
                opCtrl.branch     = 1'b1;
                opCtrl.signExt    = 1'b1;    // offset is signed
                opCtrl.aluControl = branchOp;
            end
            OP_J: begin
                opCtrl.jump    = 1'b1;
                opCtrl.signExt = 1'b1;
            end
            OP_JAL: begin
                opCtrl.jump     = 1'b1;
                opCtrl.signExt  = 1'b1;
                opCtrl.writeDst = FROM_R31;  // link into $31
            end
            OP_ADDI: begin
                opCtrl.memtoReg   = 1'b1;
                opCtrl.aluSrc2    = 1'b1;
                opCtrl.regWrite   = 1'b1;
                opCtrl.signExt    = 1'b1;
                opCtrl.aluControl = ALU_ADD;
            end
            default: opCtrl = ctrlAndWord;   // unknown opcode
        endcase
    end

    assign isRType = (op == OP_RTYPE);

    // pc select can only take one of the two
    always_comb begin
        assert #0 (!(opCtrl.branch && opCtrl.jump))
            else $error("opDecoder: branch and jump both set for op %0d", op);
    end

endmodule

`default_nettype wire

// File: hw/decode/functDecoder.sv
`default_nettype none

module functDecoder (
    input  ctrlPkg::functT    funct,
    output ctrlPkg::ctrlWordT rCtrl
);
    import ctrlPkg::*;

    // ==================================================
    // r-type decode
    // ==================================================
    // hi/lo moves share the and word, only the alu code differs
    always_comb begin
        rCtrl = ctrlAndWord;
        case (funct)
            FN_MTHI: begin
                rCtrl.aluControl = ALU_MTHI;   // rs -> hi
            end
            FN_MTLO: begin
                rCtrl.aluControl = ALU_MTLO;   // rs -> lo
            end
            FN_MFHI: begin
                rCtrl.aluControl = ALU_MFHI;   // hi -> rd
            end
            FN_MFLO: begin
                rCtrl.aluControl = ALU_MFLO;   // lo -> rd
            end
            FN_JR: begin
                // target comes from R[rs] via the pc mux
                rCtrl         = ctrlIdle;
                rCtrl.jump    = 1'b1;
                rCtrl.signExt = 1'b1;
            end
            default: begin
                rCtrl = ctrlAndWord;            // any other funct
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/ctrlMerge.sv
`default_nettype none

module ctrlMerge (
    input  logic              Clk,
    input  logic              rstN,
    input  logic              instrValid,
    input  logic              isRType,
    input  ctrlPkg::ctrlWordT opCtrl,
    input  ctrlPkg::ctrlWordT rCtrl,
    output ctrlPkg::ctrlWordT ctrl,
    output logic              ctrlValid
);
    import ctrlPkg::*;

    ctrlWordT nextCtrl;   // chosen decoder word

    // r-type words come from the funct decoder
    assign nextCtrl = isRType ? rCtrl : opCtrl;

    // ==================================================
    // id/ex control register
    // ==================================================
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            ctrl      <= ctrlIdle;
            ctrlValid <= 1'b0;
        end else begin
            ctrlValid <= instrValid;     // one cycle, every cycle
            if (instrValid) begin
                ctrl <= nextCtrl;        // hold otherwise
            end
        end
    end

    // ==================================================
    // checks
    // ==================================================
    // loads and stores never overlap at the ex stage
    memRdWrExcl: assert property (@(posedge Clk) disable iff (!rstN)
        ctrlValid |-> !(ctrl.memRead && ctrl.memWrite))
        else $error("ctrlMerge: memRead and memWrite both set");

    validKnown: assert property (@(posedge Clk) disable iff (!rstN)
        !$isunknown(ctrlValid))
        else $error("ctrlMerge: ctrlValid unknown");

endmodule

`default_nettype wire

// File: hw/ctrlUnit.sv
`default_nettype none

module ctrlUnit (
    input  logic                Clk,
    input  logic                rstN,
    input  logic                instrValid,
    input  ctrlPkg::instrFieldsT instr,
    output ctrlPkg::ctrlWordT   ctrl,
    output logic                ctrlValid
);
    import ctrlPkg::*;

    ctrlWordT opCtrl;   // opcode path
    ctrlWordT rCtrl;    // funct path
    logic     isRType;

    // both decoders run in parallel, merge picks one
    opDecoder u_opDecoder (
        .op      (instr.op),
        .rt      (instr.rt),
        .opCtrl  (opCtrl),
        .isRType (isRType)
    );

    functDecoder u_functDecoder (
        .funct (instr.funct),
        .rCtrl (rCtrl)
    );

    ctrlMerge u_ctrlMerge (
        .Clk        (Clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .isRType    (isRType),
        .opCtrl     (opCtrl),
        .rCtrl      (rCtrl),
        .ctrl       (ctrl),
        .ctrlValid  (ctrlValid)
    );

endmodule

`default_nettype wire

// File: sim/ctrlUnitTb.sv
`default_nettype none

module ctrlUnitTb;
    timeunit 1ns;
    timeprecision 1ps;

    import ctrlPkg::*;

    localparam int validTimeout = 16;   // cycles to wait for ctrlValid
    localparam int burstLen     = 24;

    // kept opcodes and function codes for the burst
    localparam logic [5:0] keptOps [16] = '{
        6'd0, 6'd1, 6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd7,
        6'd8, 6'd15, 6'd32, 6'd33, 6'd35, 6'd40, 6'd41, 6'd43
    };
    localparam logic [5:0] keptFuncts [5] = '{6'd8, 6'd16, 6'd17, 6'd18, 6'd19};

    logic        Clk;
    logic        rstN;
    logic        instrValid;
    instrFieldsT instr;
    ctrlWordT    ctrl;
    logic        ctrlValid;
    int          errorCount;

    ctrlUnit u_ctrlUnit (
        .Clk        (Clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .ctrl       (ctrl),
        .ctrlValid  (ctrlValid)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;   // 8 ns period
    end

    // ==================================================
    // helpers
    // ==================================================
    task automatic abortRun();
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] t=%0d ns %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
            abortRun();
        end
    endtask

    function automatic logic [4:0] randRt();
        logic [31:0] r;
        r = $urandom;
        return r[4:0];
    endfunction

    function automatic logic [5:0] randFunct();
        logic [31:0] r;
        r = $urandom;
        return r[5:0];
    endfunction

    // expected control word, straight from the decode rules
    function automatic ctrlWordT expectedWord(input logic [5:0] op, input logic [4:0] rt,
                                              input logic [5:0] funct);
        ctrlWordT w;
        ctrlWordT andWord;
        andWord            = '0;
        andWord.regDst     = 1'b1;
        andWord.memtoReg   = 1'b1;
        andWord.regWrite   = 1'b1;
        andWord.aluControl = ALU_AND;
        w = '0;
        case (op)
            6'd0: begin                                // r-type decodes by funct
                w = andWord;
                if (funct == 6'd17) w.aluControl = ALU_MTHI;
                else if (funct == 6'd19) w.aluControl = ALU_MTLO;
                else if (funct == 6'd16) w.aluControl = ALU_MFHI;
                else if (funct == 6'd18) w.aluControl = ALU_MFLO;
                else if (funct == 6'd8) begin          // jr
                    w         = '0;
                    w.jump    = 1'b1;
                    w.signExt = 1'b1;
                end
            end
            6'd35, 6'd32, 6'd33, 6'd15: begin           // loads and lui
                w.memRead    = (op != 6'd15);
                w.memtoReg   = (op == 6'd15);
                w.aluSrc2    = 1'b1;
                w.regWrite   = 1'b1;
                w.signExt    = 1'b1;
                w.aluControl = (op == 6'd15) ? ALU_LUI : ALU_ADD;
                w.dmControl  = (op == 6'd32) ? BYTE_LOAD : (op == 6'd33) ? HALF_LOAD : WORD_LOAD;
            end
            6'd43, 6'd40, 6'd41: begin                  // stores
                w.memWrite   = 1'b1;
                w.aluSrc2    = 1'b1;
                w.signExt    = 1'b1;
                w.aluControl = ALU_ADD;
                w.dmControl  = (op == 6'd40) ? BYTE_STORE :
                               (op == 6'd41) ? HALF_STORE : WORD_STORE;
            end
            6'd4, 6'd5, 6'd6, 6'd7, 6'd1: begin         // branches
                w.branch  = 1'b1;
                w.signExt = 1'b1;
                case (op)
                    6'd4:    w.aluControl = ALU_BEQ;
                    6'd5:    w.aluControl = ALU_BNE;
                    6'd6:    w.aluControl = ALU_BLEZ;
                    6'd7:    w.aluControl = ALU_BGTZ;
                    default: w.aluControl = (rt == 5'd1) ? ALU_BGEZ : ALU_BLTZ;
                endcase
            end
            6'd2, 6'd3: begin                           // j and jal
                w.jump    = 1'b1;
                w.signExt = 1'b1;
                if (op == 6'd3) w.writeDst = FROM_R31;
            end
            6'd8: begin                                 // addi
                w.memtoReg   = 1'b1;
                w.aluSrc2    = 1'b1;
                w.regWrite   = 1'b1;
                w.signExt    = 1'b1;
                w.aluControl = ALU_ADD;
            end
            default: w = andWord;
        endcase
        return w;
    endfunction

    task automatic drive(input logic [5:0] op, input logic [4:0] rt, input logic [5:0] funct);
        instr      = instrFieldsT'({op, rt, funct});
        instrValid = 1'b1;
    endtask

    // at least one edge before polling ctrlValid
    task automatic waitValid();
        int cycles;
        cycles = 0;
        do begin
            @(posedge Clk);
            #1;
            instrValid = 1'b0;   // single-cycle strobe
            cycles++;
        end while (!ctrlValid && cycles < validTimeout);
        if (!ctrlValid) begin
            $display("timeout: ctrlValid did not rise within %0d cycles", validTimeout);
            abortRun();
        end
    endtask

    task automatic sendAndCheck(input logic [5:0] op, input logic [4:0] rt,
                                input logic [5:0] funct, input string what);
        ctrlWordT exp;
        exp = expectedWord(op, rt, funct);
        drive(op, rt, funct);
        waitValid();
        checkEq(32'(ctrl), 32'(exp), what);
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    task automatic resetBehavior();
        rstN = 1'b0;
        repeat (4) @(posedge Clk);
        #1;
        checkEq({31'd0, ctrlValid}, 32'd0, "ctrlValid in reset");
        checkEq(32'(ctrl), 32'd0, "ctrl in reset");
        rstN  = 1'b1;
        instr = instrFieldsT'({6'd35, randRt(), randFunct()});   // valid stays low
        @(posedge Clk);
        #1;
        checkEq({31'd0, ctrlValid}, 32'd0, "ctrlValid without instrValid");
    endtask

    task automatic memoryInstrs();
        sendAndCheck(6'd35, randRt(), randFunct(), "lw");
        sendAndCheck(6'd32, randRt(), randFunct(), "lb");
        sendAndCheck(6'd33, randRt(), randFunct(), "lh");
        sendAndCheck(6'd43, randRt(), randFunct(), "sw");
        sendAndCheck(6'd40, randRt(), randFunct(), "sb");
        sendAndCheck(6'd41, randRt(), randFunct(), "sh");
        sendAndCheck(6'd15, randRt(), randFunct(), "lui");
    endtask

    task automatic branchInstrs();
        logic [31:0] r;
        logic [4:0]  rt;
        sendAndCheck(6'd4, randRt(), randFunct(), "beq");
        sendAndCheck(6'd5, randRt(), randFunct(), "bne");
        sendAndCheck(6'd7, randRt(), randFunct(), "bgtz");
        sendAndCheck(6'd6, randRt(), randFunct(), "blez");
        sendAndCheck(6'd1, 5'd1, randFunct(), "bgez");
        for (int i = 0; i < 4; i++) begin
            r  = $urandom_range(30, 0);
            rt = r[4:0];
            if (rt >= 5'd1) rt = rt + 5'd1;   // skip rt 1
            sendAndCheck(6'd1, rt, randFunct(), $sformatf("bltz rt=%0d", rt));
        end
    endtask

    task automatic jumpAndAddi();
        sendAndCheck(6'd2, randRt(), randFunct(), "j");
        sendAndCheck(6'd3, randRt(), randFunct(), "jal");
        sendAndCheck(6'd0, randRt(), 6'd8, "jr");
        sendAndCheck(6'd8, randRt(), randFunct(), "addi");
    endtask

    task automatic rTypeAndDefaults();
        logic [5:0] f;
        logic [5:0] op;
        sendAndCheck(6'd0, randRt(), 6'd17, "mthi");
        sendAndCheck(6'd0, randRt(), 6'd19, "mtlo");
        sendAndCheck(6'd0, randRt(), 6'd16, "mfhi");
        sendAndCheck(6'd0, randRt(), 6'd18, "mflo");
        f = randFunct();
        if (f == 6'd8 || (f >= 6'd16 && f <= 6'd19)) f = f + 6'd32;   // off the kept set
        sendAndCheck(6'd0, randRt(), f, $sformatf("unknown funct %0d", f));
        op = randFunct();
        for (int k = 0; k < 64; k++) begin
            if (op <= 6'd8 || op == 6'd15 || op == 6'd32 || op == 6'd33 || op == 6'd35
                || op == 6'd40 || op == 6'd41 || op == 6'd43) op = op + 6'd1;
        end
        sendAndCheck(op, randRt(), randFunct(), $sformatf("unknown op %0d", op));
    endtask

    // one instruction per cycle with results one edge later
    task automatic backToBackBurst();
        logic [31:0] r;
        logic [5:0]  op;
        logic [5:0]  funct;
        logic [4:0]  rt;
        ctrlWordT    exp;
        exp = '0;
        for (int i = 0; i < burstLen; i++) begin
            r     = $urandom_range(15, 0);
            op    = keptOps[r[3:0]];
            rt    = randRt();
            funct = randFunct();
            if (op == 6'd0) begin
                r     = $urandom_range(4, 0);
                funct = keptFuncts[r[2:0]];
            end
            exp = expectedWord(op, rt, funct);
            drive(op, rt, funct);
            @(posedge Clk);
            #1;
            checkEq({31'd0, ctrlValid}, 32'd1, $sformatf("burst %0d valid", i));
            checkEq(32'(ctrl), 32'(exp), $sformatf("burst %0d op %0d", i, op));
        end
        instrValid = 1'b0;
        @(posedge Clk);
        #1;
        checkEq({31'd0, ctrlValid}, 32'd0, "valid after burst");
        checkEq(32'(ctrl), 32'(exp), "ctrl held after burst");
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        errorCount = 0;
        void'($urandom(32'hc0e734d0));
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = instrFieldsT'(17'd0);
        resetBehavior();
        memoryInstrs();
        branchInstrs();
        jumpAndAddi();
        rTypeAndDefaults();
        backToBackBurst();
        if (errorCount == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("%0d checks failed", errorCount);
            abortRun();
        end
    end

endmodule

`default_nettype wire

// File: compile.f
common/ctrlPkg.sv
hw/decode/opDecoder.sv
hw/decode/functDecoder.sv
hw/ctrlMerge.sv
hw/ctrlUnit.sv
sim/ctrlUnitTb.sv

// File: Makefile
# Verilator build for the decode control unit

VERILATOR ?= verilator
TOP       ?= ctrlUnitTb
RTL_TOP   ?= ctrlUnit
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
LINT_FLAGS ?= --lint-only -Wall

.PHONY: all lint sim clean

all: sim

# lint the RTL and the testbench
lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FLIST) --top-module $(TOP)

# build and run, exit status is the test result
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)
